// File: bench/forwardUnitTb.sv
`timescale 1ns/1ps
`include "fwd_consts.svh"

module forwardUnitTb;
    import fwdPkg::*;

    localparam int ResetCycles   = 16;
    localparam int DirectedWords = 50;
    localparam int RandomWords   = 400;
    localparam int TimeoutCycles = (ResetCycles + DirectedWords + RandomWords) * 3 / 2;

    // Opcodes used by the directed sequences
    localparam opcodeT OpAdd  = 5'b11011;
    localparam opcodeT OpAddi = 5'b01000;
    localparam opcodeT OpLd   = 5'b10001;
    localparam opcodeT OpSt   = 5'b10000;
    localparam opcodeT OpStu  = 5'b10011;
    localparam opcodeT OpSlbi = 5'b10010;
    localparam opcodeT OpLbi  = 5'b11000;
    localparam opcodeT OpJr   = 5'b00101;
    localparam opcodeT OpJalr = 5'b00111;
    localparam opcodeT OpJal  = 5'b00110;
    localparam opcodeT OpJ    = 5'b00100;
    localparam opcodeT OpBeqz = 5'b01100;
    localparam opcodeT OpNop  = 5'b00001;

    logic     clk;
    logic     rstN;
    instWordT inst;
    logic     advance;
    fwdSelT   fwdRs;
    fwdSelT   fwdRt;
    logic     loadStall;

    // Shadow tracker, index 0 is the youngest older instruction
    destEntryT shadowQ[$];
    logic      anyAdvance;
    fwdSelT    expRs    = `FWD_NONE;
    fwdSelT    expRt    = `FWD_NONE;
    logic      expStall = 1'b0;
    logic      quietExp = 1'b1;

    int rsErrors    = 0;
    int rtErrors    = 0;
    int stallErrors = 0;
    int idleErrors  = 0;
    int reachErrors = 0;
    int stage0Hits  = 0;
    int stage1Hits  = 0;
    int stallHits   = 0;
    int maskedHits  = 0;
    int cycleCount  = 0;

    forwardUnit dut_i (
        .clk       (clk),
        .rstN      (rstN),
        .inst      (inst),
        .advance   (advance),
        .fwdRs     (fwdRs),
        .fwdRt     (fwdRt),
        .loadStall (loadStall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Instruction builders
    ////////////////////////////////////////////////////////////////////////////

    function automatic instWordT makeR(opcodeT op, regIdxT rs, regIdxT rt, regIdxT rd);
        return {op, rs, rt, rd, 2'b00};
    endfunction

    function automatic instWordT makeI(opcodeT op, regIdxT rs, regIdxT rd);
        return {op, rs, rd, 5'd4};
    endfunction

    // LBI, SLBI, jumps and branches carry an 8-bit field
    function automatic instWordT makeWide(opcodeT op, regIdxT rs, logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic void modelDecode(input instWordT w, output operandT rs,
                                        output operandT rt, output destEntryT d);
        opcodeT     op;
        // Reads rs, reads rt, writes, is a load
        logic [3:0] rule;
        regIdxT     destIdx;
        op      = w[15:11];
        rule    = 4'b0000;
        destIdx = w[10:8];
        if (op inside {5'b11001, 5'b11010, 5'b11011, [5'b11100:5'b11111]}) begin
            rule    = 4'b1110;
            destIdx = w[4:2];
        end else if (op inside {[5'b01000:5'b01011], [5'b10100:5'b10111]}) begin
            rule    = 4'b1010;
            destIdx = w[7:5];
        end else if (op == OpLd) begin
            rule    = 4'b1011;
            destIdx = w[7:5];
        end else if (op == OpSt) begin
            rule = 4'b1100;
        end else if (op == OpStu) begin
            rule = 4'b1110;
        end else if (op == OpSlbi) begin
            rule = 4'b1010;
        end else if (op == OpLbi) begin
            rule = 4'b0010;
        end else if (op == OpJr || op[4:2] == 3'b011) begin
            rule = 4'b1000;
        end else if (op == OpJalr || op == OpJal) begin
            rule    = {op == OpJalr, 3'b010};
            destIdx = 3'd7;
        end
        rs = '{regIdx: w[10:8], valid: rule[3]};
        rt = '{regIdx: w[7:5], valid: rule[2]};
        d  = '{regIdx: destIdx, valid: rule[1], isLoad: rule[0]};
    endfunction

    function automatic fwdSelT codeForAge(int age);
        if (age == 0) begin
            return `FWD_STAGE0;
        end else if (age == 1) begin
            return `FWD_STAGE1;
        end
        return `FWD_STAGE2;
    endfunction

    // Youngest matching older instruction supplies the operand
    function automatic fwdSelT expectedSel(operandT op);
        for (int k = 0; k < `FWD_STAGES; k++) begin
            if (op.valid && shadowQ[k].valid && shadowQ[k].regIdx == op.regIdx) begin
                return codeForAge(k);
            end
        end
        return `FWD_NONE;
    endfunction

    // Unused field that happens to name a live destination
    function automatic logic maskedMatch(operandT op);
        for (int k = 0; k < `FWD_STAGES; k++) begin
            if (!op.valid && shadowQ[k].valid && shadowQ[k].regIdx == op.regIdx) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    always @(posedge clk or negedge rstN) begin : shadowModel
        operandT   rsOp;
        operandT   rtOp;
        destEntryT dest;
        destEntryT blank;
        fwdSelT    rsSel;
        fwdSelT    rtSel;
        logic      stallNow;
        blank = '0;
        if (!rstN) begin
            shadowQ.delete();
            for (int k = 0; k < `FWD_STAGES; k++) begin
                shadowQ.push_back(blank);
            end
            anyAdvance = 1'b0;
            expRs    <= `FWD_NONE;
            expRt    <= `FWD_NONE;
            expStall <= 1'b0;
            quietExp <= 1'b1;
        end else begin
            modelDecode(inst, rsOp, rtOp, dest);
            rsSel    = expectedSel(rsOp);
            rtSel    = expectedSel(rtOp);
            stallNow = shadowQ[0].isLoad
                       && (rsSel == `FWD_STAGE0 || rtSel == `FWD_STAGE0);
            expRs    <= rsSel;
            expRt    <= rtSel;
            expStall <= stallNow;
            quietExp <= !anyAdvance;
            if (rsSel == `FWD_STAGE0 || rtSel == `FWD_STAGE0) begin
                stage0Hits++;
            end
            if (rsSel == `FWD_STAGE1 || rtSel == `FWD_STAGE1) begin
                stage1Hits++;
            end
            if (stallNow) begin
                stallHits++;
            end
            if (maskedMatch(rsOp) || maskedMatch(rtOp)) begin
                maskedHits++;
            end
            // Tracker moves only on advance
            if (advance) begin
                anyAdvance = 1'b1;
                shadowQ.push_front(dest);
                void'(shadowQ.pop_back());
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    rsCheck : assert property (@(posedge clk) disable iff (!rstN) fwdRs == expRs)
        else begin
            rsErrors++;
            $display("Fail %0t: fwdRs is %0d, expected %0d",
                     $time, $sampled(fwdRs), $sampled(expRs));
        end

    rtCheck : assert property (@(posedge clk) disable iff (!rstN) fwdRt == expRt)
        else begin
            rtErrors++;
            $display("Fail %0t: fwdRt is %0d, expected %0d",
                     $time, $sampled(fwdRt), $sampled(expRt));
        end

    stallCheck : assert property (@(posedge clk) disable iff (!rstN) loadStall == expStall)
        else begin
            stallErrors++;
            $display("Fail %0t: loadStall is %0b, expected %0b",
                     $time, $sampled(loadStall), $sampled(expStall));
        end

    // Empty tracker before the first advance
    idleCheck : assert property (@(posedge clk) disable iff (!rstN)
        quietExp |-> (fwdRs == `FWD_NONE && fwdRt == `FWD_NONE && !loadStall))
        else begin
            idleErrors++;
            $display("Fail %0t: outputs not idle before the first advance", $time);
        end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: stimulus still running after %0d cycles", TimeoutCycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Called on a falling edge, returns on the next one
    task automatic issue(input instWordT w, input logic adv);
        inst    = w;
        advance = adv;
        @(negedge clk);
    endtask

    initial begin
        void'($urandom(77));
        inst    = '0;
        advance = 1'b0;
        rstN    = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // Nothing tracked yet
        repeat (4) issue(16'($urandom), 1'b0);

        // Writer then readers one and two positions back
        issue(makeR(OpAdd, 3'd1, 3'd2, 3'd3), 1'b1);
        issue(makeR(OpAdd, 3'd3, 3'd4, 3'd5), 1'b1);
        issue(makeR(OpAdd, 3'd0, 3'd3, 3'd6), 1'b1);
        // Both older stages write r4
        issue(makeR(OpAdd, 3'd1, 3'd1, 3'd4), 1'b1);
        issue(makeR(OpAdd, 3'd2, 3'd2, 3'd4), 1'b1);
        issue(makeR(OpAdd, 3'd4, 3'd4, 3'd0), 1'b1);
        // Bubble between writer and reader
        issue(makeR(OpAdd, 3'd1, 3'd1, 3'd2), 1'b1);
        issue(makeR(OpAdd, 3'd2, 3'd0, 3'd1), 1'b0);
        issue(makeR(OpAdd, 3'd2, 3'd0, 3'd1), 1'b1);

        // Fields the rules ignore
        issue(makeR(OpAdd, 3'd0, 3'd0, 3'd2), 1'b1);
        issue(makeI(OpAddi, 3'd0, 3'd2), 1'b1);
        issue(makeR(OpSt, 3'd1, 3'd2, 3'd5), 1'b1);
        issue(makeR(OpAdd, 3'd5, 3'd5, 3'd0), 1'b1);
        issue(makeWide(OpBeqz, 3'd6, 8'hE0), 1'b1);
        issue(makeR(OpAdd, 3'd7, 3'd6, 3'd0), 1'b1);
        issue(makeWide(OpJ, 3'd3, 8'h1C), 1'b1);
        issue(makeR(OpAdd, 3'd3, 3'd7, 3'd1), 1'b1);

        // Link register and bits 10..8 destinations
        issue(makeWide(OpJal, 3'd0, 8'h10), 1'b1);
        issue(makeR(OpAdd, 3'd7, 3'd0, 3'd1), 1'b1);
        issue(makeWide(OpJalr, 3'd2, 8'h00), 1'b1);
        issue(makeWide(OpNop, 3'd0, 8'h00), 1'b1);
        issue(makeR(OpAdd, 3'd0, 3'd7, 3'd1), 1'b1);
        issue(makeWide(OpJr, 3'd1, 8'h00), 1'b1);
        issue(makeWide(OpLbi, 3'd5, 8'h2A), 1'b1);
        issue(makeR(OpAdd, 3'd5, 3'd0, 3'd1), 1'b1);
        issue(makeWide(OpSlbi, 3'd6, 8'h11), 1'b1);
        issue(makeR(OpAdd, 3'd0, 3'd6, 3'd1), 1'b1);
        issue(makeR(OpStu, 3'd2, 3'd3, 3'd0), 1'b1);
        issue(makeR(OpAdd, 3'd2, 3'd0, 3'd1), 1'b1);

        // Load-use right behind, then with a gap
        issue(makeI(OpLd, 3'd1, 3'd3), 1'b1);
        issue(makeR(OpAdd, 3'd3, 3'd0, 3'd1), 1'b1);
        issue(makeI(OpLd, 3'd1, 3'd4), 1'b1);
        issue(makeWide(OpNop, 3'd0, 8'h00), 1'b1);
        issue(makeR(OpAdd, 3'd0, 3'd4, 3'd1), 1'b1);

        // Random words, roughly one bubble in four
        repeat (RandomWords) issue(16'($urandom), ($urandom % 4) != 0);
        repeat (3) issue(makeWide(OpNop, 3'd0, 8'h00), 1'b1);

        if (stage0Hits == 0 || stage1Hits == 0) begin
            reachErrors++;
            $display("Stimulus never produced both stage 0 and stage 1 forwards");
        end
        if (stallHits == 0) begin
            reachErrors++;
            $display("Stimulus never produced a load-use stall");
        end
        if (maskedHits == 0) begin
            reachErrors++;
            $display("Stimulus never hit an unused field naming a live destination");
        end
        $display("Errors: fwdRs %0d, fwdRt %0d, loadStall %0d, idle %0d, unreached %0d",
                 rsErrors, rtErrors, stallErrors, idleErrors, reachErrors);
        if (rsErrors + rtErrors + stallErrors + idleErrors + reachErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+logic
logic/fwdPkg.sv
logic/instFieldDecode.sv
logic/destTracker.sv
logic/hazardComparator.sv
logic/forwardSelect.sv
logic/forwardUnit.sv
bench/forwardUnitTb.sv

// File: logic/destTracker.sv
`timescale 1ns/1ps
`include "fwd_consts.svh"

module destTracker (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               advance,
    input  fwdPkg::destEntryT                  newDest,
    output fwdPkg::destEntryT [`FWD_STAGES-1:0] entries
);

    ////////////////////////////////////////////////////////////////////////////
    // Age-ordered shift register
    ////////////////////////////////////////////////////////////////////////////

    // Entry 0 holds the instruction just ahead of the word in decode
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entries <= '0;
        end else if (advance) begin
            for (int k = `FWD_STAGES - 1; k > 0; k--) begin
                entries[k] <= entries[k-1];
            end
            entries[0] <= newDest;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Pipeline bubble, nothing moves
    holdWithoutAdvance : assert property (
        @(posedge clk) disable iff (!rstN)
        !advance |=> $stable(entries)
    ) else $error("tracker entries changed without advance");

endmodule

// File: logic/forwardSelect.sv
`timescale 1ns/1ps
`include "fwd_consts.svh"

module forwardSelect (
    input  fwdPkg::stageHitT [`FWD_STAGES-1:0] hits,
    input  logic                              stage0IsLoad,
    output fwdPkg::fwdSelT                    fwdRs,
    output fwdPkg::fwdSelT                    fwdRt,
    output logic                              loadStall
);
    import fwdPkg::*;

    // Code space must cover NONE plus one code per stage
    if (`FWD_STAGES + 1 > (1 << `FWD_SEL_W)) begin : gCodeWidthCheck
        $error("forward code too narrow for the tracked stage count");
    end

    function automatic fwdSelT stageCode(int stage);
        case (stage)
            0:       return `FWD_STAGE0;
            1:       return `FWD_STAGE1;
            default: return `FWD_STAGE2;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Priority encode, youngest result wins
    ////////////////////////////////////////////////////////////////////////////

    // Walk from the oldest stage down so a younger hit overrides
    always_comb begin
        fwdRs = `FWD_NONE;
        fwdRt = `FWD_NONE;
        for (int k = `FWD_STAGES - 1; k >= 0; k--) begin
            if (hits[k].rsHit) begin
                fwdRs = stageCode(k);
            end
            if (hits[k].rtHit) begin
                fwdRt = stageCode(k);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Load-use
    ////////////////////////////////////////////////////////////////////////////

    // Load data is not ready yet when the consumer sits right behind it
    assign loadStall = stage0IsLoad
                     && ((fwdRs == `FWD_STAGE0) || (fwdRt == `FWD_STAGE0));

endmodule

// File: logic/forwardUnit.sv
`timescale 1ns/1ps
`include "fwd_consts.svh"

module forwardUnit (
    input  logic             clk,
    input  logic             rstN,
    input  fwdPkg::instWordT inst,
    input  logic             advance,
    output fwdPkg::fwdSelT   fwdRs,
    output fwdPkg::fwdSelT   fwdRt,
    output logic             loadStall
);
    import fwdPkg::*;

    srcPairT                     srcs;
    destEntryT                   newDest;
    destEntryT [`FWD_STAGES-1:0] entries;
    stageHitT  [`FWD_STAGES-1:0] hits;
    // Lines up with the registered hits
    logic                        stage0IsLoad;

    ////////////////////////////////////////////////////////////////////////////
    // Decode and tracking
    ////////////////////////////////////////////////////////////////////////////

    instFieldDecode decode (
        .inst    (inst),
        .srcs    (srcs),
        .newDest (newDest)
    );

    destTracker tracker (
        .clk     (clk),
        .rstN    (rstN),
        .advance (advance),
        .newDest (newDest),
        .entries (entries)
    );

    ////////////////////////////////////////////////////////////////////////////
    // One comparator per older stage
    ////////////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < `FWD_STAGES; k++) begin : cmp
        hazardComparator comparator (
            .clk   (clk),
            .rstN  (rstN),
            .srcs  (srcs),
            .entry (entries[k]),
            .hit   (hits[k])
        );
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stage0IsLoad <= 1'b0;
        end else begin
            stage0IsLoad <= entries[0].isLoad;
        end
    end

    forwardSelect select (
        .hits         (hits),
        .stage0IsLoad (stage0IsLoad),
        .fwdRs        (fwdRs),
        .fwdRt        (fwdRt),
        .loadStall    (loadStall)
    );

endmodule

// File: logic/fwdPkg.sv
`include "fwd_consts.svh"

package fwdPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Plain vectors
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [15:0] instWordT;

    // Major opcode, bits 15..11
    typedef logic [4:0] opcodeT;

    typedef logic [$clog2(`NUM_REGS)-1:0] regIdxT;

    typedef logic [`FWD_SEL_W-1:0] fwdSelT;

    ////////////////////////////////////////////////////////////////////////////
    // Grouped fields
    ////////////////////////////////////////////////////////////////////////////

    // One source operand
    typedef struct packed {
        regIdxT regIdx;
        logic   valid;
    } operandT;

    // Both sources of the word in decode
    typedef struct packed {
        operandT rs;
        operandT rt;
    } srcPairT;

    // Destination of an older instruction
    typedef struct packed {
        regIdxT regIdx;
        logic   valid;
        logic   isLoad;
    } destEntryT;

    // Registered result of one stage comparator
    typedef struct packed {
        logic rsHit;
        logic rtHit;
    } stageHitT;

endpackage

// File: logic/fwd_consts.svh
`ifndef FWD_CONSTS_SVH
`define FWD_CONSTS_SVH

// Older in-flight instructions tracked, execute and memory
`define FWD_STAGES 2

// Architectural register count
`define NUM_REGS 8

// Forward-select encoding
`define FWD_SEL_W 2

// Register file value, no forwarding
`define FWD_NONE   2'd0
// Result of the instruction one position older
`define FWD_STAGE0 2'd1
// Two positions older
`define FWD_STAGE1 2'd2
// Three positions older, only with a third tracked stage
`define FWD_STAGE2 2'd3

`endif

// File: logic/hazardComparator.sv
`timescale 1ns/1ps

module hazardComparator (
    input  logic              clk,
    input  logic              rstN,
    input  fwdPkg::srcPairT   srcs,
    input  fwdPkg::destEntryT entry,
    output fwdPkg::stageHitT  hit
);
    import fwdPkg::*;

    stageHitT hitNext;

    // Invalid fields on either side never match
    function automatic logic operandMatch(operandT op, destEntryT dest);
        return op.valid && dest.valid && (op.regIdx == dest.regIdx);
    endfunction

    always_comb begin
        hitNext.rsHit = operandMatch(srcs.rs, entry);
        hitNext.rtHit = operandMatch(srcs.rt, entry);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hit <= '0;
        end else begin
            hit <= hitNext;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // A hit always traces back to a live tracked destination
    hitNeedsValidEntry : assert property (
        @(posedge clk) disable iff (!rstN)
        (hit.rsHit || hit.rtHit) |-> $past(entry.valid)
    ) else $error("comparator hit against an invalid entry");

endmodule

// File: logic/instFieldDecode.sv
`timescale 1ns/1ps
`include "fwd_consts.svh"

module instFieldDecode (
    input  fwdPkg::instWordT  inst,
    output fwdPkg::srcPairT   srcs,
    output fwdPkg::destEntryT newDest
);
    import fwdPkg::*;

    opcodeT opcode;
    // Register fields at their fixed positions
    regIdxT fieldHi;
    regIdxT fieldMid;
    regIdxT fieldLo;

    assign opcode   = inst[15:11];
    assign fieldHi  = inst[10:8];
    assign fieldMid = inst[7:5];
    assign fieldLo  = inst[4:2];

    ////////////////////////////////////////////////////////////////////////////
    // Operand and destination rules per opcode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Source indices sit in the same place for every format
        srcs.rs.regIdx = fieldHi;
        srcs.rs.valid  = 1'b0;
        srcs.rt.regIdx = fieldMid;
        srcs.rt.valid  = 1'b0;
        newDest        = '0;

        casez (opcode)
            // R-format arithmetic, shifts, sets and BTR
            5'b11001, 5'b11010, 5'b11011, 5'b111??: begin
                srcs.rs.valid  = 1'b1;
                srcs.rt.valid  = 1'b1;
                newDest.regIdx = fieldLo;
                newDest.valid  = 1'b1;
            end
            // Immediate arithmetic and immediate shifts
            5'b010??, 5'b101??: begin
                srcs.rs.valid  = 1'b1;
                newDest.regIdx = fieldMid;
                newDest.valid  = 1'b1;
            end
            // Load
            5'b10001: begin
                srcs.rs.valid  = 1'b1;
                newDest.regIdx = fieldMid;
                newDest.valid  = 1'b1;
                newDest.isLoad = 1'b1;
            end
            // Store, address and data both read
            5'b10000: begin
                srcs.rs.valid = 1'b1;
                srcs.rt.valid = 1'b1;
            end
            // STU writes the updated base back
            5'b10011: begin
                srcs.rs.valid  = 1'b1;
                srcs.rt.valid  = 1'b1;
                newDest.regIdx = fieldHi;
                newDest.valid  = 1'b1;
            end
            // SLBI, read-modify-write of rs
            5'b10010: begin
                srcs.rs.valid  = 1'b1;
                newDest.regIdx = fieldHi;
                newDest.valid  = 1'b1;
            end
            // LBI
            5'b11000: begin
                newDest.regIdx = fieldHi;
                newDest.valid  = 1'b1;
            end
            // JR
            5'b00101: begin
                srcs.rs.valid = 1'b1;
            end
            // JALR links into r7
            5'b00111: begin
                srcs.rs.valid  = 1'b1;
                newDest.regIdx = regIdxT'(`NUM_REGS - 1);
                newDest.valid  = 1'b1;
            end
            // JAL
            5'b00110: begin
                newDest.regIdx = regIdxT'(`NUM_REGS - 1);
                newDest.valid  = 1'b1;
            end
            // Branches test rs only
            5'b011??: begin
                srcs.rs.valid = 1'b1;
            end
            // J-format and everything else
            default: begin
                newDest = '0;
            end
        endcase
    end

    // A valid destination must name a real register, X included
    always_comb begin
        if (newDest.valid) begin
            assert (!$isunknown(newDest.regIdx) && (int'(newDest.regIdx) < `NUM_REGS))
                else $error("destination index %0d out of range", newDest.regIdx);
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module forwardUnitTb -f flist.f \
    && ./obj_dir/VforwardUnitTb | tee /dev/stderr | grep "TESTS PASSED" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
